/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests
SOURCES   := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/rv_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_controller (
    input  wire logic [6:0]       i_op,
    input  wire logic [2:0]       i_funct3,
    input  wire logic             i_funct7b5,
    input  wire logic             i_valid,
    output rv_pkg::ctrl_t         o_ctrl,
    output rv_pkg::imm_src_t      o_imm_src
);

    logic            is_rtype;
    rv_pkg::alu_op_t alu_dec;
    rv_pkg::ctrl_t   ctrl;

    assign is_rtype = (i_op == rv_pkg::OP_R);

    // ALU decoder, shared by R-type and I-type
    always_comb begin
        case (i_funct3)
            3'b000:  alu_dec = (is_rtype && i_funct7b5) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b010:  alu_dec = rv_pkg::ALU_SLT;
            3'b110:  alu_dec = rv_pkg::ALU_OR;
            3'b111:  alu_dec = rv_pkg::ALU_AND;
            default: alu_dec = rv_pkg::ALU_UNUSED;
        endcase
    end

    // Main decoder
    always_comb begin
        ctrl      = rv_pkg::CTRL_BUBBLE;
        o_imm_src = rv_pkg::IMM_I;
        case (i_op)
            rv_pkg::OP_R: begin
                // Unsupported funct3 stays a bubble
                if (alu_dec != rv_pkg::ALU_UNUSED) begin
                    ctrl.regwrite = 1'b1;
                    ctrl.alu_op   = alu_dec;
                end
            end
            rv_pkg::OP_I: begin
                if (alu_dec != rv_pkg::ALU_UNUSED) begin
                    ctrl.regwrite = 1'b1;
                    ctrl.alusrc   = 1'b1;
                    ctrl.alu_op   = alu_dec;
                end
            end
            rv_pkg::OP_BRANCH: begin
                // Only beq is decoded
                if (i_funct3 == 3'b000) begin
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = rv_pkg::ALU_SUB;
                end
                o_imm_src = rv_pkg::IMM_B;
            end
            rv_pkg::OP_JAL: begin
                ctrl.regwrite   = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.result_src = rv_pkg::RES_PC4;
                ctrl.alu_op     = rv_pkg::ALU_ADD;
                o_imm_src       = rv_pkg::IMM_J;
            end
            default: begin
                ctrl = rv_pkg::CTRL_BUBBLE;
            end
        endcase
    end

    assign o_ctrl = i_valid ? ctrl : rv_pkg::CTRL_BUBBLE;

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_instr_valid,
    input  wire rv_pkg::instr_t i_instr,
    input  wire rv_pkg::pc_t    i_pc,
    input  wire rv_pkg::pc_t    i_pc4,
    output rv_pkg::wb_t         o_wb,
    output logic                o_pcsrc,
    output rv_pkg::pc_t         o_pc_target
);

    rv_pkg::id_ex_t id_ex;

    // Taken branch or jump flushes decode, writeback loops into the regfile
    rv_decode_stage u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (o_pcsrc),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_pc4         (i_pc4),
        .i_wb          (o_wb),
        .o_id_ex       (id_ex)
    );

    rv_execute_stage u_execute (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_id_ex     (id_ex),
        .o_pcsrc     (o_pcsrc),
        .o_pc_target (o_pc_target),
        .o_wb        (o_wb)
    );

endmodule

`default_nettype wire

/* hdl/rv_decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode_stage (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_flush,
    input  wire logic           i_instr_valid,
    input  wire rv_pkg::instr_t i_instr,
    input  wire rv_pkg::pc_t    i_pc,
    input  wire rv_pkg::pc_t    i_pc4,
    input  wire rv_pkg::wb_t    i_wb,
    output rv_pkg::id_ex_t      o_id_ex
);

    // Instruction fields
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7b5;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd_addr;

    rv_pkg::ctrl_t     ctrl;
    rv_pkg::imm_src_t  imm_src;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     imm;
    rv_pkg::id_ex_t    id_ex_next;

    assign opcode   = i_instr[6:0];
    assign rd_addr  = i_instr[11:7];
    assign funct3   = i_instr[14:12];
    assign rs1_addr = i_instr[19:15];
    assign rs2_addr = i_instr[24:20];
    assign funct7b5 = i_instr[30];

    rv_controller u_controller (
        .i_op       (opcode),
        .i_funct3   (funct3),
        .i_funct7b5 (funct7b5),
        .i_valid    (i_instr_valid),
        .o_ctrl     (ctrl),
        .o_imm_src  (imm_src)
    );

    // Write port is fed from the EX/WB register
    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_imm_extend u_imm_extend (
        .i_instr   (i_instr),
        .i_imm_src (imm_src),
        .o_imm     (imm)
    );

    always_comb begin
        id_ex_next.ctrl     = ctrl;
        id_ex_next.rs1_data = rs1_data;
        id_ex_next.rs2_data = rs2_data;
        id_ex_next.imm      = imm;
        id_ex_next.pc       = i_pc;
        id_ex_next.pc4      = i_pc4;
        id_ex_next.rd       = rd_addr;
    end

    // ID/EX register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= rv_pkg::ID_EX_BUBBLE;
        end else if (i_flush) begin
            // Slot behind a taken branch or jump
            o_id_ex <= rv_pkg::ID_EX_BUBBLE;
        end else begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute_stage (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire rv_pkg::id_ex_t i_id_ex,
    output logic                o_pcsrc,
    output rv_pkg::pc_t         o_pc_target,
    output rv_pkg::wb_t         o_wb
);

    rv_pkg::word_t     src_b;
    rv_pkg::word_t     diff;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     result;
    logic              zero;
    logic              wb_we_q;
    rv_pkg::reg_addr_t wb_rd_q;
    rv_pkg::word_t     wb_data_q;

    assign src_b = i_id_ex.ctrl.alusrc ? i_id_ex.imm : i_id_ex.rs2_data;
    assign diff  = i_id_ex.rs1_data - src_b;
    assign zero  = (diff == '0);

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            rv_pkg::ALU_ADD: alu_result = i_id_ex.rs1_data + src_b;
            rv_pkg::ALU_SUB: alu_result = diff;
            rv_pkg::ALU_AND: alu_result = i_id_ex.rs1_data & src_b;
            rv_pkg::ALU_OR:  alu_result = i_id_ex.rs1_data | src_b;
            rv_pkg::ALU_SLT: alu_result = {{(rv_pkg::XLEN-1){1'b0}},
                                           $signed(i_id_ex.rs1_data) < $signed(src_b)};
            default:         alu_result = '0;
        endcase
    end

    // Branch and jump resolution
    assign o_pc_target = i_id_ex.pc + i_id_ex.imm[rv_pkg::PC_W-1:0];
    assign o_pcsrc     = (i_id_ex.ctrl.branch & zero) | i_id_ex.ctrl.jump;

    // jal links pc4
    assign result = (i_id_ex.ctrl.result_src == rv_pkg::RES_PC4) ?
                    {{(rv_pkg::XLEN-rv_pkg::PC_W){1'b0}}, i_id_ex.pc4} : alu_result;

    // EX/WB register, writes to x0 are dropped here
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_we_q <= 1'b0;
        end else begin
            wb_we_q <= i_id_ex.ctrl.regwrite && (i_id_ex.rd != '0);
        end
    end

    always_ff @(posedge i_clk) begin
        wb_rd_q   <= i_id_ex.rd;
        wb_data_q <= result;
    end

    assign o_wb = '{we: wb_we_q, rd: wb_rd_q, data: wb_data_q};

endmodule

`default_nettype wire

/* hdl/rv_imm_extend.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_imm_extend (
    input  wire rv_pkg::instr_t   i_instr,
    input  wire rv_pkg::imm_src_t i_imm_src,
    output rv_pkg::word_t         o_imm
);

    always_comb begin
        case (i_imm_src)
            // addi, andi, ori, slti
            rv_pkg::IMM_I: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            // beq offset, halfword aligned
            rv_pkg::IMM_B: o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                    i_instr[30:25], i_instr[11:8], 1'b0};
            // jal offset
            rv_pkg::IMM_J: o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                    i_instr[20], i_instr[30:21], 1'b0};
            default:       o_imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int PC_W   = 11;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [31:0]       instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_UNUSED
    } alu_op_t;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_B,
        IMM_J
    } imm_src_t;

    typedef enum logic [0:0] {
        RES_ALU,
        RES_PC4
    } result_src_t;

    typedef struct packed {
        logic        regwrite;
        result_src_t result_src;
        logic        alusrc;
        logic        jump;
        logic        branch;
        alu_op_t     alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        pc_t       pc;
        pc_t       pc4;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // No write, no branch, no jump
    localparam ctrl_t CTRL_BUBBLE = '{
        regwrite:   1'b0,
        result_src: RES_ALU,
        alusrc:     1'b0,
        jump:       1'b0,
        branch:     1'b0,
        alu_op:     ALU_UNUSED
    };

    localparam id_ex_t ID_EX_BUBBLE = '{
        ctrl:     CTRL_BUBBLE,
        rs1_data: '0,
        rs2_data: '0,
        imm:      '0,
        pc:       '0,
        pc4:      '0,
        rd:       '0
    };

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire rv_pkg::reg_addr_t i_rs1_addr,
    input  wire rv_pkg::reg_addr_t i_rs2_addr,
    input  wire rv_pkg::wb_t       i_wb,
    output rv_pkg::word_t          o_rs1_data,
    output rv_pkg::word_t          o_rs2_data
);

    rv_pkg::word_t regs [2**rv_pkg::REG_AW];
    logic          wr_en;

    // x0 is never written
    assign wr_en = i_wb.we && (i_wb.rd != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**rv_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // Write-first: same-cycle write is visible to the reader
    function automatic rv_pkg::word_t read_port(rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (i_wb.rd == addr)) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    // Reads follow the array and the write port as well as the addresses
    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

`default_nettype wire

/* list.f */
hdl/rv_pkg.sv
hdl/rv_controller.sv
hdl/rv_regfile.sv
hdl/rv_imm_extend.sv
hdl/rv_decode_stage.sv
hdl/rv_execute_stage.sv
hdl/rv_core_top.sv
testbench/rv_core_sva.sv
testbench/tb_rv_core.sv

/* testbench/rv_core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_sva (
    input wire logic        i_clk,
    input wire logic        i_rst_n,
    input wire rv_pkg::wb_t i_wb,
    input wire logic        i_pcsrc
);

    // x0 writes are dropped before the EX/WB register
    no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb.we |-> (i_wb.rd != '0))
        else $error("o_wb carries a write to x0");

    // Slot behind a taken branch executes as a bubble
    flush_no_pcsrc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_pcsrc) |-> !i_pcsrc)
        else $error("o_pcsrc high in the cycle after a taken branch or jump");

    flush_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_pcsrc, 2) |-> !i_wb.we)
        else $error("Flushed slot reached writeback");

    reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> (!i_pcsrc && !i_wb.we))
        else $error("o_pcsrc or o_wb write enable high during reset");

endmodule

bind rv_core_top rv_core_sva u_core_sva (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wb    (o_wb),
    .i_pcsrc (o_pcsrc)
);

`default_nettype wire

/* testbench/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    // Expected response of one instruction slot
    typedef struct packed {
        logic              we;
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t     data;
        logic              pcsrc;
        rv_pkg::pc_t       target;
    } expect_t;

    logic           i_clk;
    logic           i_rst_n;
    logic           i_instr_valid;
    rv_pkg::instr_t i_instr;
    rv_pkg::pc_t    i_pc;
    rv_pkg::pc_t    i_pc4;
    rv_pkg::wb_t    o_wb;
    logic           o_pcsrc;
    rv_pkg::pc_t    o_pc_target;

    rv_pkg::word_t  model_regs [32];
    expect_t        slot_ex;
    expect_t        slot_wb;
    rv_pkg::pc_t    cur_pc;
    logic [31:0]    lfsr_state;
    int             cycle_count = 0;
    int             cycle_limit;
    int             error_count;
    int             check_count;
    int             test_count;
    int             failed_tests;

    rv_core_top UUT (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_pc4         (i_pc4),
        .o_wb          (o_wb),
        .o_pcsrc       (o_pcsrc),
        .o_pc_target   (o_pc_target)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003)
                                       : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic rv_pkg::instr_t r_format(input logic [6:0] funct7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::instr_t i_format(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic rv_pkg::instr_t b_format(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] funct3);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::instr_t j_format(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ISA semantics of the supported ALU operations
    function automatic rv_pkg::word_t alu_ref(input logic [2:0] funct3, input logic sub,
        input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (funct3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle_count);
            error_count++;
        end
    endtask

    // Check the slots in execute and writeback, then update the model
    task automatic retire();
        check_value("o_pcsrc", 32'(o_pcsrc), 32'(slot_ex.pcsrc));
        if (slot_ex.pcsrc) begin
            check_value("o_pc_target", 32'(o_pc_target), 32'(slot_ex.target));
        end
        check_value("o_wb.we", 32'(o_wb.we), 32'(slot_wb.we));
        if (slot_wb.we) begin
            check_value("o_wb.rd", 32'(o_wb.rd), 32'(slot_wb.rd));
            check_value("o_wb.data", o_wb.data, slot_wb.data);
            model_regs[slot_wb.rd] = slot_wb.data;
        end
    endtask

    // Present one instruction for a cycle, acting as the fetch unit
    task automatic issue(input logic valid, input rv_pkg::instr_t word, input expect_t exp);
        expect_t entering;
        entering = slot_ex.pcsrc ? expect_t'('0) : exp;
        i_instr_valid = valid;
        i_instr       = word;
        i_pc          = cur_pc;
        i_pc4         = cur_pc + 11'd4;
        // Redirect after a taken branch or jump
        cur_pc = slot_ex.pcsrc ? slot_ex.target : cur_pc + 11'd4;
        @(posedge i_clk);
        #0.5;
        slot_wb = slot_ex;
        slot_ex = entering;
    endtask

    task automatic idle(input rv_pkg::instr_t word);
        retire();
        issue(1'b0, word, '0);
    endtask

    task automatic reg_op(input logic [2:0] funct3, input logic sub, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [4:0] rs2);
        expect_t exp;
        retire();
        exp      = '0;
        exp.we   = (rd != 5'd0);
        exp.rd   = rd;
        exp.data = alu_ref(funct3, sub, model_regs[rs1], model_regs[rs2]);
        issue(1'b1, r_format({1'b0, sub, 5'b0}, rs2, rs1, funct3, rd), exp);
    endtask

    task automatic imm_op(input logic [2:0] funct3, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [11:0] imm);
        expect_t exp;
        retire();
        exp      = '0;
        exp.we   = (rd != 5'd0);
        exp.rd   = rd;
        exp.data = alu_ref(funct3, 1'b0, model_regs[rs1], {{20{imm[11]}}, imm});
        issue(1'b1, i_format(imm, rs1, funct3, rd), exp);
    endtask

    task automatic branch_eq(input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [12:0] off);
        expect_t exp;
        retire();
        exp        = '0;
        exp.pcsrc  = (model_regs[rs1] == model_regs[rs2]);
        exp.target = cur_pc + off[10:0];
        issue(1'b1, b_format(off, rs2, rs1, 3'b000), exp);
    endtask

    task automatic jump_link(input logic [4:0] rd, input logic [20:0] off);
        expect_t exp;
        retire();
        exp        = '0;
        exp.we     = (rd != 5'd0);
        exp.rd     = rd;
        exp.data   = {21'b0, cur_pc + 11'd4};
        exp.pcsrc  = 1'b1;
        exp.target = cur_pc + off[10:0];
        issue(1'b1, j_format(off, rd), exp);
    endtask

    // Two empty cycles bring the last instruction through writeback
    task automatic drain();
        idle('0);
        idle('0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic reset_and_first_write();
        int errors_before;
        errors_before = error_count;
        // Instruction words with the valid strobe low must stay silent
        idle(i_format(12'h05a, 5'd0, 3'b000, 5'd1));
        idle(i_format(12'h7ff, 5'd0, 3'b000, 5'd3));
        idle(j_format(21'h000100, 5'd1));
        idle(i_format(12'h800, 5'd2, 3'b110, 5'd4));
        imm_op(3'b000, 5'd1, 5'd0, 12'(rand_bits(12)));
        drain();
        report_test("reset_and_first_write", errors_before);
    endtask

    task automatic alu_operations();
        int         errors_before;
        logic [2:0] r_funct3 [5] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b010};
        logic       r_sub    [5] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        logic [2:0] i_funct3 [4] = '{3'b000, 3'b111, 3'b110, 3'b010};
        errors_before = error_count;
        for (int round = 0; round < 4; round++) begin
            imm_op(3'b000, 5'd1, 5'd0, 12'(rand_bits(12)));
            imm_op(3'b000, 5'd2, 5'd0, 12'(rand_bits(12)));
            idle('0);
            for (int j = 0; j < 5; j++) begin
                reg_op(r_funct3[j], r_sub[j], 5'(10 + j), 5'd1, 5'd2);
                idle('0);
            end
            for (int j = 0; j < 4; j++) begin
                imm_op(i_funct3[j], 5'(15 + j), 5'd1, 12'(rand_bits(12)));
                idle('0);
            end
        end
        drain();
        report_test("alu_operations", errors_before);
    endtask

    task automatic x0_handling();
        int errors_before;
        errors_before = error_count;
        imm_op(3'b000, 5'd0, 5'd0, 12'h123);
        reg_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
        idle('0);
        reg_op(3'b000, 1'b0, 5'd20, 5'd0, 5'd0);
        idle('0);
        reg_op(3'b110, 1'b0, 5'd21, 5'd0, 5'd1);
        drain();
        report_test("x0_handling", errors_before);
    endtask

    task automatic branch_resolution();
        int          errors_before;
        logic [11:0] value;
        errors_before = error_count;
        value = 12'(rand_bits(12));
        imm_op(3'b000, 5'd1, 5'd0, value);
        imm_op(3'b000, 5'd2, 5'd0, value);
        imm_op(3'b000, 5'd3, 5'd0, value ^ 12'h001);
        idle('0);
        branch_eq(5'd1, 5'd2, {12'(rand_bits(12)), 1'b0});
        // Flushed, so x22 keeps its old value
        imm_op(3'b000, 5'd22, 5'd0, 12'h7ff);
        idle('0);
        idle('0);
        branch_eq(5'd1, 5'd3, {12'(rand_bits(12)), 1'b0});
        imm_op(3'b000, 5'd23, 5'd0, 12'h055);
        idle('0);
        reg_op(3'b000, 1'b0, 5'd24, 5'd22, 5'd0);
        idle('0);
        // Backward branch, then a jal in the flushed slot
        branch_eq(5'd0, 5'd0, 13'h1ff0);
        jump_link(5'd25, 21'h000040);
        drain();
        report_test("branch_resolution", errors_before);
    endtask

    task automatic jal_link();
        int errors_before;
        errors_before = error_count;
        jump_link(5'd5, {20'(rand_bits(20)), 1'b0});
        imm_op(3'b000, 5'd26, 5'd0, 12'h3c3);
        idle('0);
        reg_op(3'b000, 1'b0, 5'd27, 5'd5, 5'd0);
        idle('0);
        jump_link(5'd0, {20'(rand_bits(20)), 1'b0});
        idle('0);
        drain();
        report_test("jal_link", errors_before);
    endtask

    task automatic back_to_back();
        int errors_before;
        errors_before = error_count;
        for (int j = 0; j < 8; j++) begin
            imm_op(3'b000, 5'(1 + j), 5'd0, 12'(rand_bits(12)));
        end
        idle('0);
        reg_op(3'b000, 1'b0, 5'd10, 5'd1, 5'd2);
        reg_op(3'b110, 1'b0, 5'd11, 5'd3, 5'd4);
        reg_op(3'b111, 1'b0, 5'd12, 5'd5, 5'd6);
        reg_op(3'b010, 1'b0, 5'd13, 5'd7, 5'd8);
        reg_op(3'b000, 1'b1, 5'd14, 5'd8, 5'd1);
        drain();
        report_test("back_to_back", errors_before);
    endtask

    initial begin
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_pc          = '0;
        i_pc4         = '0;
        lfsr_state    = 32'hf01f5584;
        cur_pc        = '0;
        slot_ex       = '0;
        slot_wb       = '0;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // Reset plus the cycle count of each test, with a factor of two
        cycle_limit = 2 * (5 + 7 + 86 + 8 + 17 + 9 + 16);

        repeat (5) @(posedge i_clk);
        #0.5;
        i_rst_n = 1'b1;

        reset_and_first_write();
        alu_operations();
        x0_handling();
        branch_resolution();
        jal_link();
        back_to_back();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
